/* src/icache_pkg.sv */
/*
 * Instruction cache shared definitions
 * Geometry of the 4-way, 16-set cache with 128-bit lines, the address
 * overlay, tag entries, lookup and refill types, and controller states
 */
package icache_pkg;

   ////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////
   localparam int ADDR_W         = 32;
   localparam int WORD_W         = 32;
   localparam int LINE_W         = 128;
   localparam int WORDS_PER_LINE = 4;
   localparam int NB_WAYS        = 4;
   localparam int NB_SETS        = 16;
   localparam int OFFSET_W       = 4;
   localparam int SET_W          = 4;
   localparam int TAG_W          = 24;

   ////////////////////////////////////////
   // Types
   ////////////////////////////////////////
   // Overlay of a fetch address
   typedef struct packed {
      logic [TAG_W-1:0]                           tag;
      logic [SET_W-1:0]                           set;
      logic [$clog2(WORDS_PER_LINE)-1:0]          word;
      logic [OFFSET_W-$clog2(WORDS_PER_LINE)-1:0] byte_sel;
   } addr_fields_t;

   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
   } tag_entry_t;

   typedef logic [NB_WAYS-1:0] way_oh_t;

   // Result of a tag read, valid one cycle after the read
   typedef struct packed {
      logic    hit;
      way_oh_t hit_way;
      logic    all_valid;
      way_oh_t free_way;
   } lookup_t;

   typedef struct packed {
      logic              rvalid;
      logic [LINE_W-1:0] data;
   } refill_rsp_t;

   typedef enum logic [2:0] {
      DISABLED,
      BYPASS_REFILL,
      BYPASS_WAIT,
      FLUSH,
      IDLE,
      TAG_LOOKUP,
      WAIT_GNT,
      WAIT_REFILL
   } icache_state_e;

endpackage

/* src/way_replacer.sv */
/*
 * Victim way generator
 * 8-bit Fibonacci LFSR stepped once per eviction
 */
module way_replacer (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                advance_i,
   output icache_pkg::way_oh_t victim_o
);
   import icache_pkg::*;

   logic [7:0] lfsr_q;
   logic       feedback;

   // Taps for x^8 + x^6 + x^5 + x^4 + 1
   assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= 8'hb5;
      else if (advance_i)
         lfsr_q <= {lfsr_q[6:0], feedback};
   end

   assign victim_o = way_oh_t'(1) << lfsr_q[$clog2(NB_WAYS)-1:0];

endmodule

/* src/tag_store.sv */
/*
 * Tag store
 * Valid bits and tags for every way of every set, read one set at a
 * time and compared against the latched fetch tag one cycle later
 */
module tag_store (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          rd_i,
   input  logic [icache_pkg::SET_W-1:0]  set_i,
   input  logic [icache_pkg::TAG_W-1:0]  lookup_tag_i,
   input  icache_pkg::way_oh_t           wr_mask_i,
   input  icache_pkg::tag_entry_t        wr_entry_i,
   output icache_pkg::lookup_t           lookup_o
);
   import icache_pkg::*;

   logic [TAG_W-1:0]                tag_mem [NB_SETS][NB_WAYS];
   logic [NB_SETS-1:0][NB_WAYS-1:0] valid_q;
   logic [TAG_W-1:0]                rd_tag_q [NB_WAYS];
   way_oh_t                         rd_valid_q;
   way_oh_t                         match;

   // Valid bits start cleared
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q    <= '0;
         rd_valid_q <= '0;
      end
      else
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (wr_mask_i[w])
               valid_q[set_i][w] <= wr_entry_i.valid;
         end
         if (rd_i)
            rd_valid_q <= valid_q[set_i];
      end
   end

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (wr_mask_i[w])
            tag_mem[set_i][w] <= wr_entry_i.tag;
         if (rd_i)
            rd_tag_q[w] <= tag_mem[set_i][w];
      end
   end

   always_comb
   begin
      for (int w = 0; w < NB_WAYS; w++)
         match[w] = rd_valid_q[w] && (rd_tag_q[w] == lookup_tag_i);
   end

   assign lookup_o.hit       = |match;
   assign lookup_o.hit_way   = match;
   assign lookup_o.all_valid = &rd_valid_q;
   // Lowest clear valid bit, zero when the set is full
   assign lookup_o.free_way  = ~rd_valid_q & (rd_valid_q + 1'b1);

   a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(match));

endmodule

/* src/data_store.sv */
/*
 * Data store
 * Line array with one synchronous read of a whole set and a refill
 * write port, returning the addressed word of the hit way
 */
module data_store (
   input  logic                                          clk,
   input  logic                                          rd_i,
   input  logic [icache_pkg::SET_W-1:0]                  rd_set_i,
   input  icache_pkg::way_oh_t                           hit_way_i,
   input  logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0] word_i,
   input  icache_pkg::way_oh_t                           wr_mask_i,
   input  logic [icache_pkg::SET_W-1:0]                  wr_set_i,
   input  logic [icache_pkg::LINE_W-1:0]                 wr_line_i,
   output logic [icache_pkg::WORD_W-1:0]                 rdata_o
);
   import icache_pkg::*;

   logic [LINE_W-1:0]                     line_mem [NB_SETS][NB_WAYS];
   logic [LINE_W-1:0]                     rd_line_q [NB_WAYS];
   logic [WORDS_PER_LINE-1:0][WORD_W-1:0] hit_line;

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (wr_mask_i[w])
            line_mem[wr_set_i][w] <= wr_line_i;
         if (rd_i)
            rd_line_q[w] <= line_mem[rd_set_i][w];
      end
   end

   // One-hot way mux
   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (hit_way_i[w])
            hit_line |= rd_line_q[w];
      end
   end

   assign rdata_o = hit_line[word_i];

endmodule

/* src/icache_fsm.sv */
/*
 * Instruction cache controller
 * Sequences the flush sweep, tag lookup, line refill and bypass
 * transactions, and drives the fetch port handshake
 */
module icache_fsm (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          bypass_i,
   input  logic                          flush_i,
   input  logic                          fetch_req_i,
   input  icache_pkg::addr_fields_t      fetch_addr_i,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic                          rd_sel_refill_o,
   output logic                          cache_is_bypassed_o,
   output logic                          cache_is_flushed_o,
   output logic                          refill_req_o,
   output icache_pkg::addr_fields_t      refill_addr_o,
   input  logic                          refill_gnt_i,
   input  logic                          refill_valid_i,
   input  icache_pkg::lookup_t           lookup_i,
   input  icache_pkg::way_oh_t           victim_i,
   output logic                          tag_rd_o,
   output logic [icache_pkg::SET_W-1:0]  tag_set_o,
   output icache_pkg::way_oh_t           tag_wr_mask_o,
   output icache_pkg::tag_entry_t        tag_wr_entry_o,
   output icache_pkg::way_oh_t           data_wr_mask_o,
   output icache_pkg::addr_fields_t      addr_q_o,
   output logic                          advance_o
);
   import icache_pkg::*;

   icache_state_e    state_q, state_d;
   addr_fields_t     addr_q;
   way_oh_t          way_q, way_d;
   logic [SET_W-1:0] flush_cnt_q;
   logic             flush_pend_q;
   logic             flush_req;
   logic             hold_off;

   // A flush pulse seen outside IDLE waits here until the sweep starts
   assign flush_req = flush_i | flush_pend_q;
   assign hold_off  = bypass_i | flush_req;

   assign addr_q_o      = addr_q;
   assign refill_addr_o = {addr_q.tag, addr_q.set, {OFFSET_W{1'b0}}};

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q      <= DISABLED;
         way_q        <= '0;
         flush_cnt_q  <= '0;
         flush_pend_q <= 1'b0;
      end
      else
      begin
         state_q      <= state_d;
         way_q        <= way_d;
         flush_pend_q <= flush_req & (state_d != FLUSH);
         // Wraps back to zero at the end of each sweep
         if (state_q == FLUSH)
            flush_cnt_q <= flush_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
         addr_q <= fetch_addr_i;
   end

   ////////////////////////////////////////
   // Next state and outputs
   ////////////////////////////////////////
   always_comb
   begin
      state_d             = state_q;
      way_d               = way_q;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      rd_sel_refill_o     = 1'b0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      refill_req_o        = 1'b0;
      tag_rd_o            = 1'b0;
      tag_set_o           = fetch_addr_i.set;
      tag_wr_mask_o       = '0;
      tag_wr_entry_o      = '{valid: 1'b1, tag: addr_q.tag};
      data_wr_mask_o      = '0;
      advance_o           = 1'b0;

      case (state_q)
         DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            if (bypass_i)
            begin
               fetch_gnt_o = fetch_req_i;
               if (fetch_req_i)
                  state_d = BYPASS_REFILL;
            end
            else
               state_d = FLUSH;
         end
         BYPASS_REFILL:
         begin
            cache_is_bypassed_o = 1'b1;
            refill_req_o        = 1'b1;
            if (refill_gnt_i)
               state_d = BYPASS_WAIT;
         end
         BYPASS_WAIT:
         begin
            cache_is_bypassed_o = 1'b1;
            rd_sel_refill_o     = 1'b1;
            fetch_rvalid_o      = refill_valid_i;
            if (refill_valid_i)
               state_d = DISABLED;
         end
         FLUSH:
         begin
            // Clear every way of one set per cycle
            tag_set_o      = flush_cnt_q;
            tag_wr_mask_o  = '1;
            tag_wr_entry_o = '0;
            if (flush_cnt_q == SET_W'(NB_SETS - 1))
            begin
               cache_is_flushed_o = 1'b1;
               state_d            = IDLE;
            end
         end
         IDLE:
         begin
            if (bypass_i)
               state_d = DISABLED;
            else if (flush_req)
               state_d = FLUSH;
            else if (fetch_req_i)
            begin
               fetch_gnt_o = 1'b1;
               tag_rd_o    = 1'b1;
               state_d     = TAG_LOOKUP;
            end
         end
         TAG_LOOKUP:
         begin
            if (lookup_i.hit)
            begin
               // Answer this access and accept the next one in the same cycle
               fetch_rvalid_o = 1'b1;
               fetch_gnt_o    = fetch_req_i & ~hold_off;
               tag_rd_o       = fetch_gnt_o;
               if (!fetch_gnt_o)
                  state_d = IDLE;
            end
            else
            begin
               refill_req_o = 1'b1;
               advance_o    = lookup_i.all_valid;
               way_d        = lookup_i.all_valid ? victim_i : lookup_i.free_way;
               state_d      = refill_gnt_i ? WAIT_REFILL : WAIT_GNT;
            end
         end
         WAIT_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = WAIT_REFILL;
         end
         WAIT_REFILL:
         begin
            rd_sel_refill_o = 1'b1;
            fetch_rvalid_o  = refill_valid_i;
            tag_set_o       = addr_q.set;
            tag_wr_mask_o   = way_q & {NB_WAYS{refill_valid_i}};
            data_wr_mask_o  = tag_wr_mask_o;
            if (refill_valid_i)
               state_d = IDLE;
         end
         default:
            state_d = DISABLED;
      endcase
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   a_refill_hold: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=> refill_req_o && $stable(refill_addr_o));

   a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(data_wr_mask_o));

endmodule

/* src/icache_top.sv */
/*
 * Instruction cache top level
 * Controller, tag store, data store and victim generator behind a
 * req/gnt/rvalid fetch port and a single-beat line refill port
 */
module icache_top (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           bypass_i,
   input  logic                           flush_i,
   output logic                           cache_is_bypassed_o,
   output logic                           cache_is_flushed_o,
   input  logic                           fetch_req_i,
   input  logic [icache_pkg::ADDR_W-1:0]  fetch_addr_i,
   output logic                           fetch_gnt_o,
   output logic                           fetch_rvalid_o,
   output logic [icache_pkg::WORD_W-1:0]  fetch_rdata_o,
   output logic                           refill_req_o,
   output logic [icache_pkg::ADDR_W-1:0]  refill_addr_o,
   input  logic                           refill_gnt_i,
   input  icache_pkg::refill_rsp_t        refill_rsp_i
);
   import icache_pkg::*;

   addr_fields_t                          fetch_addr;
   addr_fields_t                          refill_addr;
   addr_fields_t                          addr_q;
   lookup_t                               lookup;
   way_oh_t                               victim;
   way_oh_t                               tag_wr_mask;
   way_oh_t                               data_wr_mask;
   tag_entry_t                            tag_wr_entry;
   logic                                  tag_rd;
   logic [SET_W-1:0]                      tag_set;
   logic                                  advance;
   logic                                  rd_sel_refill;
   logic [WORD_W-1:0]                     store_rdata;
   logic [WORDS_PER_LINE-1:0][WORD_W-1:0] refill_words;

   assign fetch_addr    = fetch_addr_i;
   assign refill_addr_o = refill_addr;
   assign refill_words  = refill_rsp_i.data;

   // Refill data goes straight to the fetch port on misses and bypass
   assign fetch_rdata_o = rd_sel_refill ? refill_words[addr_q.word] : store_rdata;

   icache_fsm u_fsm (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_i            (bypass_i),
      .flush_i             (flush_i),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .rd_sel_refill_o     (rd_sel_refill),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .refill_req_o        (refill_req_o),
      .refill_addr_o       (refill_addr),
      .refill_gnt_i        (refill_gnt_i),
      .refill_valid_i      (refill_rsp_i.rvalid),
      .lookup_i            (lookup),
      .victim_i            (victim),
      .tag_rd_o            (tag_rd),
      .tag_set_o           (tag_set),
      .tag_wr_mask_o       (tag_wr_mask),
      .tag_wr_entry_o      (tag_wr_entry),
      .data_wr_mask_o      (data_wr_mask),
      .addr_q_o            (addr_q),
      .advance_o           (advance)
   );

   tag_store u_tag_store (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_i         (tag_rd),
      .set_i        (tag_set),
      .lookup_tag_i (addr_q.tag),
      .wr_mask_i    (tag_wr_mask),
      .wr_entry_i   (tag_wr_entry),
      .lookup_o     (lookup)
   );

   // Data is read in the same cycle and set as the tags
   data_store u_data_store (
      .clk       (clk),
      .rd_i      (tag_rd),
      .rd_set_i  (tag_set),
      .hit_way_i (lookup.hit_way),
      .word_i    (addr_q.word),
      .wr_mask_i (data_wr_mask),
      .wr_set_i  (addr_q.set),
      .wr_line_i (refill_rsp_i.data),
      .rdata_o   (store_rdata)
   );

   way_replacer u_way_replacer (
      .clk       (clk),
      .rst_n     (rst_n),
      .advance_i (advance),
      .victim_o  (victim)
   );

endmodule

/* test/tb_icache.sv */
/*
 * Instruction cache testbench
 * Clock, reset, a refill memory responder with random delays, a random
 * fetch driver and a reference model of the fetch responses
 */
module tb_icache;
   timeunit 1ns;
   timeprecision 1ps;
   import icache_pkg::*;

   localparam int WAIT_LIMIT      = 200;
   localparam int WATCHDOG_CYCLES = 100000;
   localparam int POOL_LINES      = 48;
   localparam logic [ADDR_W-1:0] HIT_LINE  = 32'h3a5c_7190;
   localparam logic [ADDR_W-1:0] BOOT_ADDR = 32'h0000_0100;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                bypass_i;
   logic                flush_i;
   logic                fetch_req;
   logic [ADDR_W-1:0]   fetch_addr;
   logic                refill_gnt;
   refill_rsp_t         refill_rsp;
   logic                cache_is_bypassed_o;
   logic                cache_is_flushed_o;
   logic                fetch_gnt_o;
   logic                fetch_rvalid_o;
   logic [WORD_W-1:0]   fetch_rdata_o;
   logic                refill_req_o;
   logic [ADDR_W-1:0]   refill_addr_o;

   logic [31:0]         lfsr_state = 32'h7d69;
   logic [ADDR_W-1:0]   exp_addr_q [$];
   addr_fields_t        refill_lines [$];
   bit                  cached_lines [logic [TAG_W+SET_W-1:0]];
   int                  gnt_bits = 2;
   int                  held_cycles = 0;
   int                  errors = 0;
   int                  errs_at_start = 0;
   int                  tests_run = 0;
   int                  tests_failed = 0;

   icache_top u_dut (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_i            (bypass_i),
      .flush_i             (flush_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .fetch_req_i         (fetch_req),
      .fetch_addr_i        (fetch_addr),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .refill_req_o        (refill_req_o),
      .refill_addr_o       (refill_addr_o),
      .refill_gnt_i        (refill_gnt),
      .refill_rsp_i        (refill_rsp)
   );

   always #20 clk = ~clk;

   ////////////////////////////////////////
   // Model and random source
   ////////////////////////////////////////
   // Taps for x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Memory content as a fixed function of the word address
   function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
      logic [ADDR_W-1:0] a;
      a = {addr[ADDR_W-1:2], 2'b00};
      return ((a ^ 32'h5a3c_96e1) * 32'h0001_0193) + {a[15:0], a[31:16]};
   endfunction

   function automatic logic [LINE_W-1:0] line_data(input logic [ADDR_W-1:0] line_addr);
      logic [LINE_W-1:0] d;
      for (int w = 0; w < WORDS_PER_LINE; w++)
         d[w*WORD_W +: WORD_W] = mem_word(line_addr + ADDR_W'(w * 4));
      return d;
   endfunction

   // 48 lines spread over 8 sets, six per set, so evictions happen
   function automatic logic [ADDR_W-1:0] pick_addr();
      int           k;
      logic [31:0]  r;
      addr_fields_t a;
      k = int'(rand_bits(6)) % POOL_LINES;
      r = rand_bits(2);
      a.tag      = 24'h04_2000 + TAG_W'(k / 8) * 24'h00_0131;
      a.set      = SET_W'((k % 8) * 2);
      a.word     = r[1:0];
      a.byte_sel = '0;
      return a;
   endfunction

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////
   task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_line(input string name, input addr_fields_t got,
                             input addr_fields_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errs_at_start)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errs_at_start);
      end
      errs_at_start = errors;
   endtask

   ////////////////////////////////////////
   // Fetch driver
   ////////////////////////////////////////
   // Called on a rising edge, returns on the rising edge after the grant
   task automatic fetch_one(input logic [ADDR_W-1:0] addr);
      int waited;
      waited     = 0;
      fetch_req  <= 1'b1;
      fetch_addr <= addr;
      @(negedge clk);
      while (!fetch_gnt_o && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (fetch_gnt_o)
         exp_addr_q.push_back(addr);
      else
      begin
         errors++;
         $display("Timeout at %0t: fetch of %h was never granted", $time, addr);
      end
      @(posedge clk);
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_addr_q.size() != 0 && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         waited++;
      end
      if (exp_addr_q.size() != 0)
      begin
         errors++;
         $display("Timeout at %0t: %0d fetches never answered", $time, exp_addr_q.size());
         exp_addr_q.delete();
      end
   endtask

   task automatic random_fetches(input int n);
      int gap;
      for (int i = 0; i < n; i++)
      begin
         fetch_one(pick_addr());
         gap = int'(rand_bits(2));
         if (gap != 0)
         begin
            fetch_req <= 1'b0;
            repeat (gap) @(posedge clk);
         end
      end
      fetch_req <= 1'b0;
      drain();
   endtask

   task automatic wait_flushed(output int cycles);
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
         check_flag("fetch_gnt_o", fetch_gnt_o, 1'b0);
      end
      while (!cache_is_flushed_o && cycles < WAIT_LIMIT);
      if (!cache_is_flushed_o)
      begin
         errors++;
         $display("Timeout at %0t: cache_is_flushed_o never pulsed", $time);
      end
      cached_lines.delete();
      @(posedge clk);
   endtask

   ////////////////////////////////////////
   // Refill responder and monitor
   ////////////////////////////////////////
   initial
   begin : refill_responder
      addr_fields_t line;
      int           gnt_wait;
      int           rsp_wait;
      forever
      begin
         @(negedge clk);
         if (rst_n && refill_req_o)
         begin
            line = addr_fields_t'(refill_addr_o);
            refill_lines.push_back(line);
            gnt_wait = int'(rand_bits(gnt_bits));
            rsp_wait = int'(rand_bits(2));
            // Address must hold while the grant is withheld
            for (int i = 0; i < gnt_wait; i++)
            begin
               @(negedge clk);
               held_cycles++;
               check_flag("refill_req_o", refill_req_o, 1'b1);
               check_line("refill_addr_o", addr_fields_t'(refill_addr_o), line);
            end
            @(posedge clk);
            refill_gnt <= 1'b1;
            @(posedge clk);
            refill_gnt <= 1'b0;
            repeat (rsp_wait) @(posedge clk);
            refill_rsp <= '{rvalid: 1'b1, data: line_data(line)};
            @(posedge clk);
            refill_rsp <= '{rvalid: 1'b0, data: '0};
         end
      end
   end

   always @(negedge clk)
   begin
      logic [ADDR_W-1:0] a;
      if (rst_n && fetch_rvalid_o)
      begin
         if (exp_addr_q.size() == 0)
         begin
            errors++;
            $display("Error at %0t: fetch_rvalid_o without an accepted fetch", $time);
         end
         else
         begin
            a = exp_addr_q.pop_front();
            check_word("fetch_rdata_o", fetch_rdata_o, mem_word(a));
            if (!bypass_i)
               cached_lines[a[ADDR_W-1:OFFSET_W]] = 1'b1;
         end
      end
      if (rst_n && refill_req_o && fetch_gnt_o)
      begin
         errors++;
         $display("Error at %0t: fetch granted while a refill waits for grant", $time);
      end
   end

   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Simulation stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial
   begin : main
      int cycles;
      int n0;
      rst_n      = 1'b0;
      bypass_i   = 1'b0;
      flush_i    = 1'b0;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      refill_gnt = 1'b0;
      refill_rsp = '{rvalid: 1'b0, data: '0};
      repeat (3) @(posedge clk);
      rst_n      <= 1'b1;
      // A fetch already waits while the sweep runs
      fetch_req  <= 1'b1;
      fetch_addr <= BOOT_ADDR;

      // One DISABLED cycle, then NB_SETS flush cycles
      wait_flushed(cycles);
      check_word("flush length", WORD_W'(cycles), WORD_W'(NB_SETS + 1));
      fetch_one(BOOT_ADDR);
      fetch_req <= 1'b0;
      drain();
      end_test("reset_flush");

      random_fetches(400);
      end_test("random_data");

      fetch_one(HIT_LINE);
      fetch_req <= 1'b0;
      drain();
      n0 = refill_lines.size();
      fetch_one(HIT_LINE + 32'h8);
      fetch_req <= 1'b0;
      @(negedge clk);
      check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b1);
      check_flag("refill_req_o", refill_req_o, 1'b0);
      @(posedge clk);
      drain();
      check_word("refill count", WORD_W'(refill_lines.size()), WORD_W'(n0));
      end_test("hit_no_refill");

      // Before the flush the line is still resident
      n0 = refill_lines.size();
      fetch_one(HIT_LINE + 32'h4);
      fetch_req <= 1'b0;
      drain();
      check_word("refill count", WORD_W'(refill_lines.size()),
                 WORD_W'(cached_lines.exists(HIT_LINE[ADDR_W-1:OFFSET_W]) ? n0 : n0 + 1));
      flush_i <= 1'b1;
      @(posedge clk);
      flush_i <= 1'b0;
      wait_flushed(cycles);
      n0 = refill_lines.size();
      fetch_one(HIT_LINE + 32'h4);
      fetch_req <= 1'b0;
      drain();
      check_word("refill count", WORD_W'(refill_lines.size()), WORD_W'(n0 + 1));
      if (refill_lines.size() > n0)
         check_line("refill_addr_o", refill_lines[n0], addr_fields_t'(HIT_LINE));
      end_test("flush_invalidates");

      bypass_i <= 1'b1;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!cache_is_bypassed_o && cycles < WAIT_LIMIT);
      check_flag("cache_is_bypassed_o", cache_is_bypassed_o, 1'b1);
      @(posedge clk);
      n0 = refill_lines.size();
      random_fetches(24);
      check_word("refill count", WORD_W'(refill_lines.size()), WORD_W'(n0 + 24));
      n0 = refill_lines.size();
      fetch_one(HIT_LINE);
      fetch_one(HIT_LINE);
      fetch_req <= 1'b0;
      drain();
      check_word("refill count", WORD_W'(refill_lines.size()), WORD_W'(n0 + 2));
      @(negedge clk);
      check_flag("cache_is_bypassed_o", cache_is_bypassed_o, 1'b1);
      @(posedge clk);
      bypass_i <= 1'b0;
      wait_flushed(cycles);
      end_test("bypass");

      // Grant delays up to 15 cycles
      gnt_bits    = 4;
      held_cycles = 0;
      random_fetches(60);
      if (held_cycles == 0)
      begin
         errors++;
         $display("Error: no refill was held back by a withheld grant");
      end
      end_test("refill_backpressure");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* build.f */
src/icache_pkg.sv
src/way_replacer.sv
src/tag_store.sv
src/data_store.sv
src/icache_fsm.sv
src/icache_top.sv
test/tb_icache.sv

/* Makefile */
SIM      = verilator
TOP      = tb_icache
RTL_TOP  = icache_top
FILELIST = build.f
FLAGS    = --binary --timing --assert -Wno-fatal
OUTDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OUTDIR) -o V$(TOP)

run: build
	./$(OUTDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OUTDIR) $(LOG)
